// ==== fmaAdderPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// half-precision field widths and stage structs
// normal numbers only, the hidden one is always assumed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fmaAdderPkg;

    // exponent and stored fraction widths of a binary16 word
    localparam int expW = 5;
    localparam int fracW = 10;

    // significand including the hidden one
    localparam int sigW = fracW + 1;

    // exponent gap at which the smaller operand can no longer reach the kept bits
    localparam int domThresh = 11;

    // carry bit, significand, and room for the largest alignment shift
    localparam int sumW = 1 + sigW + (domThresh - 1);

    // leading-zero count over the sum field, 0 to sumW-1
    localparam int lzcW = $clog2(sumW);

    // one half-precision word
    typedef struct packed {
        logic             sign;
        logic [expW-1:0]  exp;
        logic [fracW-1:0] frac;
    } halfT;

    // stage 1 to stage 2 payload
    typedef struct packed {
        // larger-exponent significand at the top of the field, carry bit clear
        logic [sumW-1:0] bigSig;
        // other significand, already shifted right by the exponent gap
        logic [sumW-1:0] smallSig;
        logic [expW-1:0] bigExp;
        // signs differ, so magnitudes are subtracted
        logic            effSub;
        logic            bigSign;
        logic            smallSign;
        // exponent gap reached domThresh
        logic            passThru;
        // dominant operand as it must leave the pipe
        halfT            passWord;
    } alignedT;

endpackage

`default_nettype wire

// ==== leadZeroCount.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational leading-zero count over the sum field
// count reads zero when the field is all zero, check allZero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module leadZeroCount (
    input  logic [fmaAdderPkg::sumW-1:0] sumField,
    output logic [fmaAdderPkg::lzcW-1:0] zeroCount,
    output logic                         allZero
);
    import fmaAdderPkg::*;

    // priority search, scanning upward so the topmost one wins
    always_comb begin
        zeroCount = '0;
        for (int i = 0; i < sumW; i++) begin
            if (sumField[i]) begin
                zeroCount = lzcW'(sumW - 1 - i);
            end
        end
    end

    // exact cancellation of equal magnitudes
    assign allZero = ~|sumField;

endmodule

`default_nettype wire

// ==== alignStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage 1 of the addend adder, one cycle
// operands are taken as normal numbers, no special values
// payload loads only on inValid, s1Valid follows inValid
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module alignStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  fmaAdderPkg::halfT    product,
    input  fmaAdderPkg::halfT    addend,
    input  logic                 negZ,
    output logic                 s1Valid,
    output fmaAdderPkg::alignedT s1Data
);
    import fmaAdderPkg::*;

    // zero padding below the significand in the sum field
    localparam int padW = sumW - sigW - 1;

    // addend after the negate control
    halfT            addendNeg;

    // operands ordered by magnitude
    logic            productBig;
    halfT            bigOp;
    halfT            smallOp;

    // alignment
    logic [expW-1:0] expDiff;
    logic [sigW-1:0] bigSigRaw;
    logic [sigW-1:0] smallSigRaw;
    logic [sumW-1:0] bigPlaced;
    logic [sumW-1:0] smallPlaced;

    // next value of the stage register
    alignedT         alignNext;

    // negate only flips the sign, magnitude is untouched
    always_comb begin
        addendNeg = addend;
        addendNeg.sign = addend.sign ^ negZ;
    end

    // exponent first, fraction breaks the tie
    // equal magnitudes keep the product as the big operand
    assign productBig = {product.exp, product.frac} >= {addendNeg.exp, addendNeg.frac};

    assign bigOp = productBig ? product : addendNeg;
    assign smallOp = productBig ? addendNeg : product;

    // never negative since bigOp has the larger exponent
    assign expDiff = bigOp.exp - smallOp.exp;

    // restore the hidden one
    assign bigSigRaw = {1'b1, bigOp.frac};
    assign smallSigRaw = {1'b1, smallOp.frac};

    // both start just under the carry bit
    assign bigPlaced = {1'b0, bigSigRaw, {padW{1'b0}}};

    // for gaps up to 10 the shifted-out bits land in the padding, nothing is lost
    // larger gaps drop bits but then passThru overrides the sum
    assign smallPlaced = {1'b0, smallSigRaw, {padW{1'b0}}} >> expDiff;

    always_comb begin
        alignNext.bigSig = bigPlaced;
        alignNext.smallSig = smallPlaced;
        alignNext.bigExp = bigOp.exp;
        alignNext.effSub = bigOp.sign ^ smallOp.sign;
        alignNext.bigSign = bigOp.sign;
        alignNext.smallSign = smallOp.sign;
        alignNext.passThru = expDiff >= expW'(domThresh);
        // already carries the negated addend sign when the addend dominates
        alignNext.passWord = bigOp;
    end

    // stage valid
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= inValid;
        end
    end

    // payload, held between strobes
    always_ff @(posedge clk) begin
        if (inValid) begin
            s1Data <= alignNext;
        end
    end

endmodule

`default_nettype wire

// ==== normalizeStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage 2 of the addend adder, one cycle
// fraction is truncated, exponent wraps modulo 32
// result loads only on s1Valid and holds otherwise
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module normalizeStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 s1Valid,
    input  fmaAdderPkg::alignedT s1Data,
    output logic                 outValid,
    output fmaAdderPkg::halfT    result
);
    import fmaAdderPkg::*;

    // magnitude path
    logic [sumW-1:0]  sumField;
    logic [lzcW-1:0]  zeroCount;
    logic             allZero;
    logic [sumW-1:0]  normSig;

    // packed result fields
    logic [expW-1:0]  normExp;
    logic [fracW-1:0] normFrac;
    halfT             resultNext;

    // big operand is never smaller, so subtraction cannot go negative
    // same-sign add may set the carry bit at the top of the field
    always_comb begin
        if (s1Data.effSub) begin
            sumField = s1Data.bigSig - s1Data.smallSig;
        end else begin
            sumField = s1Data.bigSig + s1Data.smallSig;
        end
    end

    leadZeroCount lzcInst (
        .sumField  (sumField),
        .zeroCount (zeroCount),
        .allZero   (allZero)
    );

    // move the leading one up to the carry position
    assign normSig = sumField << zeroCount;

    // keep the 10 bits right below the leading one, the rest is dropped
    assign normFrac = normSig[sumW-2 -: fracW];

    // count 1 means no carry and no cancellation, exponent unchanged
    // count 0 is a carry out, deeper counts are cancellation
    assign normExp = s1Data.bigExp + expW'(1) - zeroCount;

    // dominance wins over the sum, then cancellation
    always_comb begin
        if (s1Data.passThru) begin
            resultNext = s1Data.passWord;
        end else if (allZero) begin
            // cancellation needs differing signs, result is +0
            resultNext = '0;
        end else begin
            resultNext.sign = s1Data.bigSign;
            resultNext.exp = normExp;
            resultNext.frac = normFrac;
        end
    end

    // output strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= s1Valid;
        end
    end

    // result word, reads zero out of reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
        end else if (s1Valid) begin
            result <= resultNext;
        end
    end

endmodule

`default_nettype wire

// ==== fmaAdder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// addend stage of a half-precision FMA, two-cycle latency
// takes a strobe every cycle, no back-pressure
// no rounding, subnormals, zero, inf or NaN handling
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module fmaAdder (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  fmaAdderPkg::halfT product,
    input  fmaAdderPkg::halfT addend,
    input  logic              negZ,
    output logic              outValid,
    output fmaAdderPkg::halfT result
);
    import fmaAdderPkg::*;

    // stage 1 to stage 2
    logic    s1Valid;
    alignedT s1Data;

    // negate, order, align
    alignStage alignInst (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .product (product),
        .addend  (addend),
        .negZ    (negZ),
        .s1Valid (s1Valid),
        .s1Data  (s1Data)
    );

    // add or subtract, normalize, pick the output word
    normalizeStage normInst (
        .clk      (clk),
        .rstN     (rstN),
        .s1Valid  (s1Valid),
        .s1Data   (s1Data),
        .outValid (outValid),
        .result   (result)
    );

endmodule

`default_nettype wire

// ==== fmaAdderModel.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integer reference model of the addend adder
// same truncation and exponent wrap as the RTL
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FMA_ADDER_MODEL_SVH
`define FMA_ADDER_MODEL_SVH

// addend after the negate control
function automatic fmaAdderPkg::halfT modelNegate(
    input fmaAdderPkg::halfT z,
    input logic              negZ
);
    fmaAdderPkg::halfT r;
    r = z;
    r.sign = z.sign ^ negZ;
    return r;
endfunction

// expected result word for one operand pair
function automatic fmaAdderPkg::halfT modelAdd(
    input fmaAdderPkg::halfT p,
    input fmaAdderPkg::halfT z,
    input logic              negZ
);
    fmaAdderPkg::halfT a;
    fmaAdderPkg::halfT bigOp;
    fmaAdderPkg::halfT smallOp;
    fmaAdderPkg::halfT res;
    int                diff;
    int                bigMag;
    int                smallMag;
    int                mag;
    int                lz;
    int                expOut;
    a = modelNegate(z, negZ);
    // product stays big on a magnitude tie
    if ({p.exp, p.frac} >= {a.exp, a.frac}) begin
        bigOp = p;
        smallOp = a;
    end else begin
        bigOp = a;
        smallOp = p;
    end
    diff = int'(bigOp.exp) - int'(smallOp.exp);
    if (diff >= fmaAdderPkg::domThresh) begin
        return bigOp;
    end
    // scaled by 2^10 so the shifted significand stays exact
    bigMag = (1024 + int'(bigOp.frac)) * 1024;
    smallMag = ((1024 + int'(smallOp.frac)) * 1024) >> diff;
    if (bigOp.sign != smallOp.sign) begin
        mag = bigMag - smallMag;
    end else begin
        mag = bigMag + smallMag;
    end
    if (mag == 0) begin
        return '0;
    end
    // leading one goes to bit 21, the carry position
    lz = 0;
    while (mag < (1 << 21)) begin
        mag = mag * 2;
        lz++;
    end
    expOut = int'(bigOp.exp) + 1 - lz;
    res.sign = bigOp.sign;
    res.exp = fmaAdderPkg::expW'(expOut);
    res.frac = fmaAdderPkg::fracW'(mag >> 11);
    return res;
endfunction

`endif

// ==== fmaAdderTb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random testbench for the addend adder, fixed seed
// inputs change on the rising edge, outputs are sampled on the falling edge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module fmaAdderTb;
    import fmaAdderPkg::*;

    `include "fmaAdderModel.svh"

    localparam int unsigned seed = 32'h7d49;
    localparam int numTxn = 400;
    localparam int clkPeriod = 4;
    localparam int resetCycles = 4;
    localparam int drainCycles = 8;
    // at most 4 cycles per strobe are used, so 8 leaves ample margin
    localparam int timeoutNs = numTxn * 8 * clkPeriod + resetCycles * clkPeriod;

    // DUT connections
    logic clk = 1'b0;
    logic rstN;
    logic inValid;
    halfT product;
    halfT addend;
    logic negZ;
    logic outValid;
    halfT result;

    // scoreboard, expected word and the cycle it is due
    halfT expQ[$];
    int   dueQ[$];

    int   cycle = 0;
    int   errors = 0;
    int   checks = 0;
    int   strobes = 0;
    int   results = 0;
    bit   seenResult = 1'b0;

    fmaAdder uut (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .product  (product),
        .addend   (addend),
        .negZ     (negZ),
        .outValid (outValid),
        .result   (result)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // any normal word, no special values exist in this format
    function automatic halfT randomWord();
        halfT w;
        w.sign = 1'($urandom());
        w.exp = expW'($urandom());
        w.frac = fracW'($urandom());
        return w;
    endfunction

    // compare outputs at the falling edge, after the edge in cycle
    task automatic checkOutputs();
        halfT expWord;
        int   due;
        checks++;
        if (!rstN) begin
            // both registers must sit at zero while reset is held
            if (outValid !== 1'b0) begin
                errors++;
                $display("MISMATCH outValid in reset: expected 0, got %h", outValid);
            end
            if (result !== halfT'(0)) begin
                errors++;
                $display("MISMATCH result in reset: expected 0000, got %h", result);
            end
        end else if (outValid === 1'b1) begin
            results++;
            seenResult = 1'b1;
            if (expQ.size() == 0) begin
                errors++;
                $display("extra result at cycle %0d with no strobe pending", cycle);
            end else begin
                expWord = expQ.pop_front();
                due = dueQ.pop_front();
                if (due != cycle) begin
                    errors++;
                    $display("result arrived in cycle %0d but was due in cycle %0d",
                             cycle, due);
                end
                if (result !== expWord) begin
                    errors++;
                    $display("MISMATCH result at cycle %0d: expected %h, got %h",
                             cycle, expWord, result);
                end
            end
        end else begin
            if (outValid !== 1'b0) begin
                errors++;
                $display("MISMATCH outValid at cycle %0d: expected 0, got %h", cycle, outValid);
            end
            // result keeps its reset value until the first strobe comes out
            if (!seenResult && result !== halfT'(0)) begin
                errors++;
                $display("MISMATCH result after reset: expected 0000, got %h", result);
            end
            if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
                errors++;
                $display("no result in cycle %0d for the strobe due then", dueQ[0]);
                void'(expQ.pop_front());
                void'(dueQ.pop_front());
            end
        end
    endtask

    // one clock: drive on the rising edge, check on the falling edge
    task automatic driveCycle(input logic v, input halfT p, input halfT z, input logic nz);
        @(posedge clk);
        cycle++;
        inValid <= v;
        product <= p;
        addend <= z;
        negZ <= nz;
        if (v) begin
            strobes++;
            expQ.push_back(modelAdd(p, z, nz));
            dueQ.push_back(cycle + 2);
        end
        @(negedge clk);
        checkOutputs();
    endtask

    // operand pair from one of several classes
    // bigW and smallW carry effective signs, the addend sign is undone at the end
    task automatic makeOperands(output halfT p, output halfT z, output logic nz);
        halfT bigW;
        halfT smallW;
        int   kind;
        int   d;
        int   delta;
        kind = int'($urandom_range(5, 0));
        nz = 1'($urandom());
        bigW = randomWord();
        smallW = randomWord();
        case (kind)
            // same sign, gap below domThresh, top exponents exercise the carry
            0: begin
                bigW.exp = expW'($urandom_range(30, 10));
                d = int'($urandom_range(domThresh - 1, 0));
                smallW.exp = bigW.exp - expW'(d);
                smallW.sign = bigW.sign;
            end
            // opposite signs, gap below domThresh
            1: begin
                bigW.exp = expW'($urandom_range(30, 10));
                d = int'($urandom_range(domThresh - 1, 0));
                smallW.exp = bigW.exp - expW'(d);
                smallW.sign = ~bigW.sign;
            end
            // near-equal magnitudes, long leading-zero runs
            2: begin
                smallW.sign = ~bigW.sign;
                if ($urandom_range(1, 0) == 0) begin
                    delta = int'($urandom_range(8, 0)) - 4;
                    smallW.exp = bigW.exp;
                    smallW.frac = bigW.frac + fracW'(delta);
                end else begin
                    // 1.0 against 0.11111111111, only the last bit survives
                    bigW.exp = expW'($urandom_range(30, 12));
                    bigW.frac = '0;
                    smallW.exp = bigW.exp - expW'(1);
                    smallW.frac = '1;
                end
            end
            // exact cancellation
            3: begin
                smallW = bigW;
                smallW.sign = ~bigW.sign;
            end
            // dominant operand, gap of domThresh or more
            4: begin
                bigW.exp = expW'($urandom_range(31, 20));
                d = int'($urandom_range(20, domThresh));
                smallW.exp = bigW.exp - expW'(d);
            end
            default: begin
            end
        endcase
        if ($urandom_range(1, 0) == 0) begin
            p = bigW;
            z = smallW;
        end else begin
            p = smallW;
            z = bigW;
        end
        z.sign = z.sign ^ nz;
    endtask

    // stop a hung run
    initial begin
        #(timeoutNs);
        $display("watchdog expired after %0d ns, the run did not finish", timeoutNs);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        halfT p;
        halfT z;
        logic nz;
        int   maxGap;
        int   gap;
        void'($urandom(seed));
        rstN <= 1'b0;
        inValid <= 1'b0;
        product <= '0;
        addend <= '0;
        negZ <= 1'b0;
        maxGap = 0;

        // reset with garbage on the data inputs
        repeat (resetCycles) driveCycle(1'b0, randomWord(), randomWord(), 1'b0);
        rstN <= 1'b1;
        repeat (3) driveCycle(1'b0, randomWord(), randomWord(), 1'b0);

        for (int t = 0; t < numTxn; t++) begin
            // strobe density changes every 25 pairs, 0 gives back-to-back strobes
            if (t % 25 == 0) begin
                maxGap = int'($urandom_range(3, 0));
            end
            makeOperands(p, z, nz);
            driveCycle(1'b1, p, z, nz);
            gap = (maxGap == 0) ? 0 : int'($urandom_range(maxGap, 0));
            repeat (gap) driveCycle(1'b0, randomWord(), randomWord(), 1'b0);
        end

        repeat (drainCycles) driveCycle(1'b0, randomWord(), randomWord(), 1'b0);
        if (expQ.size() != 0) begin
            errors++;
            $display("%0d results never arrived", expQ.size());
        end

        $display("strobes %0d, results %0d, checks %0d, errors %0d",
                 strobes, results, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fmaAdder.f ====
+incdir+.
fmaAdderPkg.sv
leadZeroCount.sv
alignStage.sv
normalizeStage.sv
fmaAdder.sv
fmaAdderTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = fmaAdderTb
FILELIST  = fmaAdder.f
OBJDIR    = obj_dir

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJDIR)
